// ==== hdl/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and address width
`define RV_XLEN 32

// register file geometry
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// one strobe per byte lane
`define RV_WSTRB_W 4

`define RV_INSTR_BYTES 4
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcode, instr[6:0]
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_funct_e;

  // width in the low two bits, bit 2 set for zero extension
  typedef enum logic [2:0] {
    mem_byte   = 3'b000,
    mem_half   = 3'b001,
    mem_word   = 3'b010,
    mem_byte_u = 3'b100,
    mem_half_u = 3'b101
  } mem_funct_e;

  typedef enum logic [2:0] {
    fn_add_sub = 3'b000,
    fn_sll     = 3'b001,
    fn_slt     = 3'b010,
    fn_sltu    = 3'b011,
    fn_xor     = 3'b100,
    fn_srl_sra = 3'b101,
    fn_or      = 3'b110,
    fn_and     = 3'b111
  } alu_funct_e;

endpackage

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

  typedef enum logic [3:0] {
    st_fetch, st_fetch_wait, st_decode, st_execute,
    st_load_wait, st_store_wait, st_write_back, st_trapped
  } cpu_state_e;

  // arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt,
    alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_eq, alu_ne,
    alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [3:0] {
    cls_alu, cls_lui, cls_auipc, cls_jal, cls_jalr,
    cls_branch, cls_load, cls_store, cls_illegal
  } instr_class_e;

  typedef enum logic [1:0] {
    size_byte, size_half, size_word
  } access_size_e;

endpackage

// ==== hdl/rv_decoder.sv ====
`include "rv_consts.svh"

module rv_decoder
  import rv_core_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic [`RV_XLEN-1:0]       instr,
  output instr_class_e              instr_class,
  output alu_op_e                   alu_op,
  output logic                      use_imm,
  output logic [`RV_XLEN-1:0]       immediate,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output access_size_e              access_size,
  output logic                      load_unsigned
);

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                alt_ok;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct7 0100000 only selects sub and sra
  assign alt_ok = funct7 == 7'b0100000 &&
                  (funct3 == 3'b101 || (funct3 == 3'b000 && opcode == opc_op));

  always_comb begin
    instr_class   = cls_illegal;
    alu_op        = alu_add;
    use_imm       = 1'b1;
    immediate     = imm_i;
    access_size   = size_word;
    load_unsigned = 1'b0;
    case (opcode)
      opc_lui: begin
        instr_class = cls_lui;
        immediate   = imm_u;
      end
      opc_auipc: begin
        instr_class = cls_auipc;
        immediate   = imm_u;
      end
      opc_jal: begin
        instr_class = cls_jal;
        immediate   = imm_j;
      end
      opc_jalr: if (funct3 == 3'b000) instr_class = cls_jalr;
      opc_branch: begin
        instr_class = cls_branch;
        use_imm     = 1'b0;
        immediate   = imm_b;
        case (branch_funct_e'(funct3))
          br_beq:  alu_op = alu_eq;
          br_bne:  alu_op = alu_ne;
          br_blt:  alu_op = alu_lt;
          br_bge:  alu_op = alu_ge;
          br_bltu: alu_op = alu_ltu;
          br_bgeu: alu_op = alu_geu;
          default: instr_class = cls_illegal;
        endcase
      end
      opc_load, opc_store: begin
        instr_class   = (opcode == opc_load) ? cls_load : cls_store;
        immediate     = (opcode == opc_load) ? imm_i : imm_s;
        load_unsigned = funct3[2];
        case (mem_funct_e'(funct3))
          mem_byte: access_size = size_byte;
          mem_half: access_size = size_half;
          mem_word: access_size = size_word;
          mem_byte_u, mem_half_u: begin
            access_size = funct3[0] ? size_half : size_byte;
            // no unsigned stores
            if (opcode == opc_store) instr_class = cls_illegal;
          end
          default: instr_class = cls_illegal;
        endcase
      end
      opc_op_imm, opc_op: begin
        instr_class = cls_alu;
        use_imm     = opcode == opc_op_imm;
        case (alu_funct_e'(funct3))
          fn_add_sub: alu_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
          fn_sll:     alu_op = alu_sll;
          fn_slt:     alu_op = alu_slt;
          fn_sltu:    alu_op = alu_sltu;
          fn_xor:     alu_op = alu_xor;
          fn_srl_sra: alu_op = funct7[5] ? alu_sra : alu_srl;
          fn_or:      alu_op = alu_or;
          fn_and:     alu_op = alu_and;
        endcase
        // funct7 is only a real field for register ops and shifts
        if ((opcode == opc_op || funct3[1:0] == 2'b01) && funct7 != 7'b0 && !alt_ok) begin
          instr_class = cls_illegal;
        end
      end
      // ecall, ebreak and csr access all trap
      opc_system: instr_class = cls_illegal;
      default: instr_class = cls_illegal;
    endcase
    if (instr[1:0] != 2'b11) instr_class = cls_illegal;
  end

endmodule

// ==== hdl/rv_regfile.sv ====
`include "rv_consts.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data,
  input  logic                      rd_we,
  input  logic [`RV_REG_ADDR_W-1:0] rd_addr,
  input  logic [`RV_XLEN-1:0]       rd_wdata
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rd_we && rd_addr != '0) regs[rd_addr] <= rd_wdata;
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/rv_alu.sv ====
`include "rv_consts.svh"

module rv_alu
  import rv_core_pkg::*;
(
  input  alu_op_e             alu_op,
  input  logic [`RV_XLEN-1:0] alu_a,
  input  logic [`RV_XLEN-1:0] alu_b,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic                alu_cond
);

  logic [4:0] shamt;
  logic       eq, lt, ltu;

  assign shamt = alu_b[4:0];
  assign eq    = alu_a == alu_b;
  assign lt    = $signed(alu_a) < $signed(alu_b);
  assign ltu   = alu_a < alu_b;

  always_comb begin
    alu_result = '0;
    alu_cond   = 1'b0;
    case (alu_op)
      alu_add:  alu_result = alu_a + alu_b;
      alu_sub:  alu_result = alu_a - alu_b;
      alu_sll:  alu_result = alu_a << shamt;
      alu_slt:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt};
      alu_sltu: alu_result = {{(`RV_XLEN-1){1'b0}}, ltu};
      alu_xor:  alu_result = alu_a ^ alu_b;
      alu_srl:  alu_result = alu_a >> shamt;
      alu_sra:  alu_result = $signed(alu_a) >>> shamt;
      alu_or:   alu_result = alu_a | alu_b;
      alu_and:  alu_result = alu_a & alu_b;
      // branch compares, result stays zero
      alu_eq:   alu_cond = eq;
      alu_ne:   alu_cond = !eq;
      alu_lt:   alu_cond = lt;
      alu_ge:   alu_cond = !lt;
      alu_ltu:  alu_cond = ltu;
      alu_geu:  alu_cond = !ltu;
    endcase
  end

endmodule

// ==== hdl/rv_lsu_align.sv ====
`include "rv_consts.svh"

module rv_lsu_align
  import rv_core_pkg::*;
(
  input  logic [1:0]             addr_low,
  input  access_size_e           access_size,
  input  logic                   load_unsigned,
  input  logic [`RV_XLEN-1:0]    rs2_data,
  input  logic [`RV_XLEN-1:0]    mem_rdata,
  output logic [`RV_WSTRB_W-1:0] store_wstrb,
  output logic [`RV_XLEN-1:0]    store_wdata,
  output logic [`RV_XLEN-1:0]    load_data,
  output logic                   misaligned
);

  logic [`RV_XLEN-1:0] lane;
  logic                sign;

  // selected lane moved down to bit 0
  assign lane = mem_rdata >> {addr_low, 3'b000};

  always_comb begin
    case (access_size)
      size_byte: begin
        sign        = lane[7] & ~load_unsigned;
        store_wdata = {4{rs2_data[7:0]}};
        store_wstrb = 4'b0001 << addr_low;
        load_data   = {{24{sign}}, lane[7:0]};
        misaligned  = 1'b0;
      end
      size_half: begin
        sign        = lane[15] & ~load_unsigned;
        store_wdata = {2{rs2_data[15:0]}};
        store_wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
        load_data   = {{16{sign}}, lane[15:0]};
        misaligned  = addr_low[0];
      end
      default: begin
        sign        = 1'b0;
        store_wdata = rs2_data;
        store_wstrb = 4'b1111;
        load_data   = mem_rdata;
        misaligned  = addr_low != 2'b00;
      end
    endcase
  end

endmodule

// ==== hdl/rv_control.sv ====
`include "rv_consts.svh"

module rv_control
  import rv_core_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  output logic                      mem_valid,
  output logic                      mem_instr,
  input  logic                      mem_ready,
  output logic [`RV_XLEN-1:0]       mem_addr,
  output logic [`RV_XLEN-1:0]       mem_wdata,
  output logic [`RV_WSTRB_W-1:0]    mem_wstrb,
  input  logic [`RV_XLEN-1:0]       mem_rdata,
  output logic                      trap,
  output logic [`RV_XLEN-1:0]       instr,
  input  instr_class_e              instr_class,
  input  alu_op_e                   alu_op,
  input  logic                      use_imm,
  input  logic [`RV_XLEN-1:0]       immediate,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic [`RV_XLEN-1:0]       rs1_data,
  input  logic [`RV_XLEN-1:0]       rs2_data,
  output logic [`RV_XLEN-1:0]       alu_a,
  output logic [`RV_XLEN-1:0]       alu_b,
  input  logic [`RV_XLEN-1:0]       alu_result,
  input  logic                      alu_cond,
  input  logic [`RV_WSTRB_W-1:0]    store_wstrb,
  input  logic [`RV_XLEN-1:0]       store_wdata,
  input  logic [`RV_XLEN-1:0]       load_data,
  input  logic                      misaligned,
  output logic                      rd_we,
  output logic [`RV_REG_ADDR_W-1:0] rd_addr,
  output logic [`RV_XLEN-1:0]       rd_wdata
);

  cpu_state_e          state;
  logic [`RV_XLEN-1:0] pc, next_pc, pc_plus4, pc_target, exec_wb, wb_data;
  logic                mem_access, take_trap;

  assign pc_plus4  = pc + `RV_INSTR_BYTES;
  assign pc_target = pc + immediate;

  always_comb begin
    case (instr_class)
      cls_jal:    next_pc = pc_target;
      cls_jalr:   next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      cls_branch: next_pc = alu_cond ? pc_target : pc_plus4;
      default:    next_pc = pc_plus4;
    endcase
    case (instr_class)
      cls_lui:           exec_wb = immediate;
      cls_jal, cls_jalr: exec_wb = pc_plus4;
      default:           exec_wb = alu_result;
    endcase
  end

  assign mem_access = instr_class == cls_load || instr_class == cls_store;
  // only jumps and taken branches can leave word alignment
  assign take_trap  = instr_class == cls_illegal || (mem_access && misaligned) ||
                      next_pc[1:0] != 2'b00;

  assign alu_a    = (instr_class == cls_auipc) ? pc : rs1_data;
  assign alu_b    = use_imm ? immediate : rs2_data;
  assign rd_we    = state == st_write_back;
  assign rd_addr  = rd;
  assign rd_wdata = wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_fetch;
      pc        <= `RV_RESET_PC;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      trap      <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= '0;
          state     <= st_fetch_wait;
        end
        st_fetch_wait: if (mem_ready) begin
          mem_valid <= 1'b0;
          state     <= st_decode;
        end
        st_decode: state <= st_execute;
        st_execute: begin
          if (take_trap) begin
            trap  <= 1'b1;
            state <= st_trapped;
          end else begin
            pc <= next_pc;
            if (mem_access) begin
              mem_valid <= 1'b1;
              mem_instr <= 1'b0;
              mem_wstrb <= (instr_class == cls_store) ? store_wstrb : '0;
              state     <= (instr_class == cls_store) ? st_store_wait : st_load_wait;
            end else begin
              state <= (instr_class == cls_branch) ? st_fetch : st_write_back;
            end
          end
        end
        st_load_wait: if (mem_ready) begin
          mem_valid <= 1'b0;
          state     <= st_write_back;
        end
        st_store_wait: if (mem_ready) begin
          mem_valid <= 1'b0;
          state     <= st_fetch;
        end
        st_write_back: state <= st_fetch;
        default: state <= st_trapped;
      endcase
    end
  end

  // bus payload, instruction and result registers
  always_ff @(posedge clk) begin
    case (state)
      st_fetch: mem_addr <= pc;
      st_fetch_wait: if (mem_ready) instr <= mem_rdata;
      st_execute: begin
        mem_addr  <= {alu_result[`RV_XLEN-1:2], 2'b00};
        mem_wdata <= store_wdata;
        wb_data   <= exec_wb;
      end
      st_load_wait: if (mem_ready) wb_data <= load_data;
      default: ;
    endcase
  end

  bus_hold: assert property (@(posedge clk) disable iff (reset)
    (mem_valid && !mem_ready) |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata) &&
    $stable(mem_wstrb) && $stable(mem_instr));

  trap_is_final: assert property (@(posedge clk) disable iff (reset)
    trap |=> trap && !mem_valid);

  // decoder and ALU must agree on the compare for branches
  branch_uses_compare: assert property (@(posedge clk) disable iff (reset)
    (state == st_execute && instr_class == cls_branch) |->
    alu_op inside {alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu});

endmodule

// ==== hdl/rv_core.sv ====
`include "rv_consts.svh"

module rv_core
  import rv_core_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  output logic                   mem_valid,
  output logic                   mem_instr,
  input  logic                   mem_ready,
  output logic [`RV_XLEN-1:0]    mem_addr,
  output logic [`RV_XLEN-1:0]    mem_wdata,
  output logic [`RV_WSTRB_W-1:0] mem_wstrb,
  input  logic [`RV_XLEN-1:0]    mem_rdata,
  output logic                   trap
);

  logic [`RV_XLEN-1:0]       instr, immediate, rs1_data, rs2_data;
  logic [`RV_XLEN-1:0]       alu_a, alu_b, alu_result, rd_wdata;
  logic [`RV_XLEN-1:0]       store_wdata, load_data;
  logic [`RV_WSTRB_W-1:0]    store_wstrb;
  logic [`RV_REG_ADDR_W-1:0] rd, rs1, rs2, rd_addr;
  logic                      use_imm, load_unsigned, alu_cond, misaligned, rd_we;
  instr_class_e              instr_class;
  alu_op_e                   alu_op;
  access_size_e              access_size;

  rv_control u_control (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr, .mem_wdata,
    .mem_wstrb, .mem_rdata, .trap, .instr, .instr_class, .alu_op, .use_imm,
    .immediate, .rd, .rs1_data, .rs2_data, .alu_a, .alu_b, .alu_result, .alu_cond,
    .store_wstrb, .store_wdata, .load_data, .misaligned, .rd_we, .rd_addr, .rd_wdata
  );

  rv_decoder u_decoder (
    .instr, .instr_class, .alu_op, .use_imm, .immediate, .rd, .rs1, .rs2,
    .access_size, .load_unsigned
  );

  rv_regfile u_regfile (
    .clk, .rs1, .rs2, .rs1_data, .rs2_data, .rd_we, .rd_addr, .rd_wdata
  );

  rv_alu u_alu (
    .alu_op, .alu_a, .alu_b, .alu_result, .alu_cond
  );

  rv_lsu_align u_lsu_align (
    .addr_low (alu_result[1:0]),
    .access_size,
    .load_unsigned,
    .rs2_data,
    .mem_rdata,
    .store_wstrb,
    .store_wdata,
    .load_data,
    .misaligned
  );

endmodule

// ==== tb/rv_ref_pkg.sv ====
`include "rv_consts.svh"

package rv_ref_pkg;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int MEM_WORDS = 1024;
  localparam int BODY_LEN  = 48;
  // one addi per register ahead of the body
  localparam int INIT_LEN  = `RV_NUM_REGS - 1;
  // register init, body, store-all sequence, trap word, and some slack
  localparam int PROG_MAX  = INIT_LEN + BODY_LEN + 40;
  localparam int DATA_BASE = 'h600;
  localparam int DUMP_BASE = 'h700;

  int seed = 22938;

  // image seen on the bus, and the model's own copy
  logic [`RV_XLEN-1:0] img [0:MEM_WORDS-1];
  logic [`RV_XLEN-1:0] ref_mem [0:MEM_WORDS-1];
  logic [`RV_XLEN-1:0] ref_regs [0:`RV_NUM_REGS-1];
  logic [`RV_XLEN-1:0] ref_pc;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [31:0] alu_result_of(logic [2:0] f3, bit alt, logic [31:0] a,
                                                logic [31:0] b);
    logic [31:0] res;
    case (alu_funct_e'(f3))
      fn_add_sub: res = alt ? a - b : a + b;
      fn_sll:     res = a << b[4:0];
      fn_slt:     res = {31'b0, $signed(a) < $signed(b)};
      fn_sltu:    res = {31'b0, a < b};
      fn_xor:     res = a ^ b;
      fn_srl_sra: begin
        if (alt) res = $unsigned($signed(a) >>> b[4:0]);
        else res = a >> b[4:0];
      end
      fn_or:      res = a | b;
      fn_and:     res = a & b;
    endcase
    return res;
  endfunction

  // one instruction at ref_pc; state is left alone when it traps
  function automatic void model_step(output bit traps, output bit st,
                                     output logic [31:0] st_addr, output logic [3:0] st_strb,
                                     output logic [31:0] st_data);
    logic [31:0] ins, a, b, imm_i, imm_s, imm_b, imm_j, ea, lane, res, nxt;
    logic [2:0]  f3;
    logic [4:0]  rd;
    bit          wr, alt, is_op, taken, f7_used, f7_alt_ok;
    int          i;
    ins   = ref_mem[ref_pc[11:2]];
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = ref_regs[ins[19:15]];
    b     = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    ea    = a + ((ins[6:0] == opc_store) ? imm_s : imm_i);
    lane  = ref_mem[ea[11:2]] >> (8 * ea[1:0]);
    is_op = ins[6:0] == opc_op;
    alt   = ins[30] && (is_op || f3 == 3'b101);
    res     = '0;
    nxt     = ref_pc + 4;
    wr      = 1'b0;
    taken   = 1'b0;
    st      = 1'b0;
    traps   = 1'b0;
    st_addr = {ea[31:2], 2'b00};
    st_strb = '0;
    st_data = b;
    case (opcode_e'(ins[6:0]))
      opc_lui: begin
        res = {ins[31:12], 12'b0};
        wr  = 1'b1;
      end
      opc_auipc: begin
        res = ref_pc + {ins[31:12], 12'b0};
        wr  = 1'b1;
      end
      opc_jal: begin
        res = ref_pc + 4;
        nxt = ref_pc + imm_j;
        wr  = 1'b1;
      end
      opc_jalr: begin
        res   = ref_pc + 4;
        nxt   = (a + imm_i) & ~32'd1;
        wr    = 1'b1;
        traps = f3 != 3'b000;
      end
      opc_branch: begin
        case (branch_funct_e'(f3))
          br_beq:  taken = a == b;
          br_bne:  taken = a != b;
          br_blt:  taken = $signed(a) < $signed(b);
          br_bge:  taken = $signed(a) >= $signed(b);
          br_bltu: taken = a < b;
          br_bgeu: taken = a >= b;
          default: traps = 1'b1;
        endcase
        if (taken) nxt = ref_pc + imm_b;
      end
      opc_load: begin
        wr = 1'b1;
        case (mem_funct_e'(f3))
          mem_byte:   res = {{24{lane[7]}}, lane[7:0]};
          mem_byte_u: res = {24'b0, lane[7:0]};
          mem_half:   res = {{16{lane[15]}}, lane[15:0]};
          mem_half_u: res = {16'b0, lane[15:0]};
          mem_word:   res = lane;
          default:    traps = 1'b1;
        endcase
        if ((f3[0] && ea[0]) || (f3[1] && ea[1:0] != 2'b00)) traps = 1'b1;
      end
      opc_store: begin
        st = 1'b1;
        case (mem_funct_e'(f3))
          mem_byte: begin
            st_strb = 4'b0001 << ea[1:0];
            st_data = {4{b[7:0]}};
          end
          mem_half: begin
            st_strb = 4'b0011 << ea[1:0];
            st_data = {2{b[15:0]}};
          end
          mem_word: st_strb = 4'b1111;
          default:  traps = 1'b1;
        endcase
        if ((f3[0] && ea[0]) || (f3[1] && ea[1:0] != 2'b00)) traps = 1'b1;
      end
      opc_op_imm, opc_op: begin
        wr        = 1'b1;
        res       = alu_result_of(f3, alt, a, is_op ? b : imm_i);
        f7_used   = is_op || f3[1:0] == 2'b01;
        f7_alt_ok = ins[31:25] == 7'h20 && (f3 == 3'b101 || (is_op && f3 == 3'b000));
        if (f7_used && ins[31:25] != 7'h00 && !f7_alt_ok) traps = 1'b1;
      end
      // system, unknown opcodes, and words without 11 in the low bits
      default: traps = 1'b1;
    endcase
    if (nxt[1:0] != 2'b00) traps = 1'b1;
    if (traps) begin
      st = 1'b0;
    end else begin
      if (wr && rd != 5'd0) ref_regs[rd] = res;
      if (st) begin
        for (i = 0; i < 4; i++) begin
          if (st_strb[i]) ref_mem[ea[11:2]][8*i +: 8] = st_data[8*i +: 8];
        end
      end
      ref_pc = nxt;
    end
  endfunction

  function automatic void generate_program(int idx);
    logic [31:0] ins, r;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    int          k, skip, i;
    for (i = 0; i < MEM_WORDS; i++) img[i] = {~i[15:0], i[15:0]};
    for (i = DATA_BASE / 4; i < DUMP_BASE / 4; i++) img[i] = $random(seed);
    // registers keep their old contents over reset, so give each a start value
    for (i = 1; i < `RV_NUM_REGS; i++) begin
      r = $random(seed);
      img[i - 1] = {r[31:20], 5'd0, 3'b000, 5'(i), opc_op_imm};
    end
    for (k = 0; k < BODY_LEN; k++) begin
      r    = $random(seed);
      rd   = 5'(1 + rand_below(31));
      rs1  = r[19:15];
      rs2  = r[24:20];
      f3   = r[14:12];
      skip = rand_below(4);
      // forward targets stay inside the body or land on the first store
      if (k + 1 + skip > BODY_LEN) skip = BODY_LEN - k - 1;
      boff = 13'(4 * (1 + skip));
      joff = 21'(4 * (1 + skip));
      case (rand_below(9))
        0, 1, 2, 3: begin
          if (r[1]) begin
            ins = {(f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[30], 5'b0} : 7'b0,
                   rs2, rs1, f3, rd, opc_op};
          end else begin
            imm = (f3[1:0] == 2'b01) ? {1'b0, r[30] & f3[2], 5'b0, r[24:20]} : r[31:20];
            ins = {imm, rs1, f3, rd, opc_op_imm};
          end
        end
        4: ins = {r[31:12], rd, r[0] ? opc_lui : opc_auipc};
        5: begin
          f3 = 3'(rand_below(3));
          if (f3 != 3'b010 && r[0]) f3[2] = 1'b1;
          imm = 12'(DATA_BASE + (rand_below(256) & ~((1 << f3[1:0]) - 1)));
          ins = {imm, 5'd0, f3, rd, opc_load};
        end
        6: begin
          f3  = 3'(rand_below(3));
          imm = 12'(DATA_BASE + (rand_below(256) & ~((1 << f3[1:0]) - 1)));
          ins = {imm[11:5], rs2, 5'd0, f3, imm[4:0], opc_store};
        end
        7: begin
          if (f3[2:1] == 2'b01) f3[2] = 1'b1;
          ins = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], opc_branch};
        end
        default: begin
          if (r[0]) begin
            ins = {joff[20], joff[10:1], joff[11], joff[19:12], rd, opc_jal};
          end else begin
            imm = 12'(4 * (INIT_LEN + k + 1 + skip));
            ins = {imm, 5'd0, 3'b000, rd, opc_jalr};
          end
        end
      endcase
      img[INIT_LEN + k] = ins;
    end
    // store every register to the dump area
    for (i = 1; i < `RV_NUM_REGS; i++) begin
      imm = 12'(DUMP_BASE + 4 * i);
      img[INIT_LEN + BODY_LEN + i - 1] = {imm[11:5], 5'(i), 5'd0, 3'b010, imm[4:0], opc_store};
    end
    case (idx % 4)
      0: ins = 32'h0000_0073;
      1: ins = 32'h0000_0000;
      2: ins = {12'h602, 5'd0, 3'b010, 5'd1, opc_load};
      default: ins = {1'b0, 10'd3, 1'b0, 8'd0, 5'd1, opc_jal};
    endcase
    img[INIT_LEN + BODY_LEN + `RV_NUM_REGS - 1] = ins;
    for (i = 0; i < MEM_WORDS; i++) ref_mem[i] = img[i];
    for (i = 0; i < `RV_NUM_REGS; i++) ref_regs[i] = '0;
    ref_pc = `RV_RESET_PC;
  endfunction

endpackage

// ==== tb/rv_core_tb.sv ====
`include "rv_consts.svh"

module rv_core_tb
  import rv_ref_pkg::*;
();

  localparam int NUM_TESTS   = 8;
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   mem_valid, mem_instr, mem_ready, trap;
  logic [`RV_XLEN-1:0]    mem_addr, mem_wdata, mem_rdata;
  logic [`RV_WSTRB_W-1:0] mem_wstrb;
  int                     test_errors;
  int                     total_errors = 0;
  int                     failed_tests = 0;

  rv_core dut (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr, .mem_wdata,
    .mem_wstrb, .mem_rdata, .trap
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin : watchdog
    #(NUM_TESTS * PROG_MAX * 12 * CLK_PERIOD);
    $display("watchdog expired before the last test finished");
    $display("Testbench failed");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("** Error: time %0t, %s: got %h, expected %h", $time, name, got, exp);
    test_errors++;
  endtask

  task automatic report_failure(string what);
    $display("time %0t: %s", $time, what);
    test_errors++;
  endtask

  task automatic run_test(int idx);
    bit                     busy, done, trap_exp, st_exp, traps, st, held;
    logic [`RV_XLEN-1:0]    st_addr, st_data, held_addr, held_wdata;
    logic [`RV_WSTRB_W-1:0] st_strb, held_wstrb;
    logic                   held_instr;
    int                     wait_cycles, instrs, stores, quiet, late, b;
    test_errors = 0;
    busy        = 1'b0;
    done        = 1'b0;
    trap_exp    = 1'b0;
    st_exp      = 1'b0;
    held        = 1'b0;
    wait_cycles = 0;
    instrs      = 0;
    stores      = 0;
    quiet       = 0;
    late        = 0;
    generate_program(idx);
    reset     = 1'b1;
    mem_ready = 1'b0;
    repeat (2) begin
      next_cycle();
      if (mem_valid !== 1'b0 || trap !== 1'b0) report_failure("mem_valid or trap high in reset");
    end
    reset = 1'b0;
    while (!done) begin
      next_cycle();
      // a request left waiting must not move
      if (held) begin
        if (mem_valid !== 1'b1) report_failure("mem_valid dropped while mem_ready was low");
        if (mem_addr !== held_addr) report_mismatch("mem_addr", mem_addr, held_addr);
        if (mem_wdata !== held_wdata) report_mismatch("mem_wdata", mem_wdata, held_wdata);
        if (mem_wstrb !== held_wstrb) report_mismatch("mem_wstrb", 32'(mem_wstrb), 32'(held_wstrb));
        if (mem_instr !== held_instr) report_mismatch("mem_instr", 32'(mem_instr), 32'(held_instr));
      end
      if (mem_ready) begin
        mem_ready = 1'b0;
        busy      = 1'b0;
      end else if (mem_valid && !busy) begin
        busy        = 1'b1;
        wait_cycles = rand_below(4);
        if (trap_exp) report_failure("bus request after the instruction that should trap");
        if (!mem_instr && instrs == 0) report_failure("first request after reset is not a fetch");
        if (mem_instr) begin
          if (st_exp) report_failure("store predicted by the model never reached the bus");
          if (mem_addr !== ref_pc) report_mismatch("fetch mem_addr", mem_addr, ref_pc);
          if (mem_wstrb !== '0) report_mismatch("fetch mem_wstrb", 32'(mem_wstrb), 32'd0);
          model_step(traps, st, st_addr, st_strb, st_data);
          trap_exp = traps;
          st_exp   = st;
          instrs++;
        end else if (mem_wstrb != '0) begin
          stores++;
          if (!st_exp) begin
            report_failure("write request with no store in the model");
          end else begin
            if (mem_addr !== st_addr) report_mismatch("store mem_addr", mem_addr, st_addr);
            if (mem_wstrb !== st_strb) report_mismatch("mem_wstrb", 32'(mem_wstrb), 32'(st_strb));
            if (mem_wdata !== st_data) report_mismatch("mem_wdata", mem_wdata, st_data);
          end
          st_exp = 1'b0;
        end
      end
      if (busy) begin
        if (wait_cycles > 0) begin
          wait_cycles--;
        end else begin
          mem_ready = 1'b1;
          if (mem_wstrb == '0) begin
            mem_rdata = img[mem_addr[11:2]];
          end else begin
            for (b = 0; b < `RV_WSTRB_W; b++) begin
              if (mem_wstrb[b]) img[mem_addr[11:2]][8*b +: 8] = mem_wdata[8*b +: 8];
            end
          end
        end
      end
      held       = mem_valid && !mem_ready;
      held_addr  = mem_addr;
      held_wdata = mem_wdata;
      held_wstrb = mem_wstrb;
      held_instr = mem_instr;
      if (trap === 1'b1) begin
        if (!trap_exp) report_failure("trap rose with no trapping instruction in the model");
        if (mem_valid !== 1'b0) report_failure("mem_valid high after trap");
        quiet++;
        if (quiet == 5) done = 1'b1;
      end else if (trap_exp) begin
        late++;
        if (late > 12) report_failure("trap did not rise after the trapping instruction");
      end
      if (test_errors != 0) done = 1'b1;
    end
    $display("test %0d: %0d instructions, %0d stores, trap kind %0d, %s",
             idx, instrs, stores, idx % 4, (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin : main
    reset     = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
      total_errors += test_errors;
      if (test_errors != 0) failed_tests++;
    end
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu_align.sv
hdl/rv_control.sv
hdl/rv_core.sv
tb/rv_ref_pkg.sv
tb/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module rv_core_tb -f filelist.f \
    -Mdir obj_dir -o rv_core_tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/rv_core_tb_sim)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_output"; then
  exit 0
fi
exit 1
